/* include/hostLink_consts.svh */
`ifndef HOSTLINK_CONSTS_SVH
`define HOSTLINK_CONSTS_SVH

// ------------------------------------------------------------
// host pipe word layout
// ------------------------------------------------------------
// one host pipe word
`define HL_WORD_W 32
// opcode sits in the top byte of every word
`define HL_CODE_W 8
// padding opcode, dropped downstream and inserted upstream
`define HL_NOP_CODE 64

// queue depths in words
`define HL_DS_DEPTH 16
`define HL_US_DEPTH 16

// ------------------------------------------------------------
// AXI4-Lite register byte offsets
// ------------------------------------------------------------
`define HL_REG_CTRL 'h00
`define HL_REG_STATUS 'h04
`define HL_REG_DSCOUNT 'h08
`define HL_REG_NOPCOUNT 'h0C
`define HL_REG_PADCOUNT 'h10

`endif

/* hdl/hostLinkPkg.sv */
`include "hostLink_consts.svh"

package hostLinkPkg;

  // ------------------------------------------------------------
  // downstream word, after the NOP filter
  // ------------------------------------------------------------
  // code is the top byte of the host word
  // payload is everything below it
  typedef struct packed {
    logic [`HL_CODE_W-1:0] code;
    logic [`HL_WORD_W-`HL_CODE_W-1:0] payload;
  } dsWord_t;

  // ------------------------------------------------------------
  // upstream word
  // ------------------------------------------------------------
  // passed to the host as is, no field split
  typedef logic [`HL_WORD_W-1:0] usWord_t;

endpackage

/* hdl/wordFifo.sv */
module wordFifo #(
  parameter type itemType = logic [31:0],
  parameter int depth = 16
) (
  input  logic clk,
  input  logic rstN,
  input  logic flush,
  input  logic pushValid,
  input  itemType pushData,
  output logic full,
  input  logic popReady,
  output logic popValid,
  output itemType popData,
  output logic [$clog2(depth + 1)-1:0] level
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  // ring storage behind the head register
  itemType mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] memCount;

  // head entry, drives the pop side straight from flops
  logic headValid;
  itemType headData;

  logic pushFire;
  logic popFire;
  logic headLoad;
  logic memPop;
  logic bypass;
  logic memPush;

  // wrap for depths that are not a power of two
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    logic [ptrW-1:0] nxt;
    nxt = (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // level counts the head entry too
  assign level = memCount + cntW'(headValid);
  assign full = (level == cntW'(depth));
  assign popValid = headValid;
  assign popData = headData;

  assign pushFire = pushValid & ~full;
  assign popFire = headValid & popReady;
  // head is free this cycle, or is being emptied
  assign headLoad = ~headValid | popFire;
  assign memPop = headLoad & (memCount != '0);
  // ring empty, so a new push goes straight to the head
  assign bypass = headLoad & (memCount == '0) & pushFire;
  assign memPush = pushFire & ~bypass;

  // ------------------------------------------------------------
  // control state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      memCount <= '0;
      headValid <= 1'b0;
    end else begin
      if (memPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (memPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({memPush, memPop})
        2'b10: memCount <= memCount + 1'b1;
        2'b01: memCount <= memCount - 1'b1;
        default: memCount <= memCount;
      endcase
      if (headLoad) begin
        headValid <= memPop | bypass;
      end
    end
  end

  // storage and head payload
  always_ff @(posedge clk) begin
    if (memPush) begin
      mem[wrPtr] <= pushData;
    end
    if (memPop) begin
      headData <= mem[rdPtr];
    end else if (bypass) begin
      headData <= pushData;
    end
  end

endmodule

/* hdl/pipeInDecoder.sv */
`include "hostLink_consts.svh"

module pipeInDecoder (
  input  logic pipeInWrite,
  input  logic [`HL_WORD_W-1:0] pipeInData,
  output logic pipeInReady,
  input  logic dsEnable,
  input  logic fifoFull,
  output logic pushValid,
  output hostLinkPkg::dsWord_t pushData,
  output logic nopSeen
);

  localparam int payloadW = `HL_WORD_W - `HL_CODE_W;

  logic accept;
  logic isNop;
  logic [`HL_CODE_W-1:0] wordCode;

  // ------------------------------------------------------------
  // host side flow control
  // ------------------------------------------------------------
  // take words only while the direction is on and there is room
  assign pipeInReady = dsEnable & ~fifoFull;
  assign accept = pipeInWrite & pipeInReady;

  // ------------------------------------------------------------
  // opcode classification
  // ------------------------------------------------------------
  // opcode lives in the top byte
  assign wordCode = pipeInData[`HL_WORD_W-1 -: `HL_CODE_W];
  assign isNop = (wordCode == `HL_CODE_W'(`HL_NOP_CODE));

  // padding is dropped here and only counted
  assign nopSeen = accept & isNop;
  // real words go to the queue in the same cycle
  assign pushValid = accept & ~isNop;

  // split into code and payload
  assign pushData.code = wordCode;
  assign pushData.payload = pipeInData[payloadW-1:0];

endmodule

/* hdl/pipeOutPacker.sv */
`include "hostLink_consts.svh"

module pipeOutPacker (
  input  logic clk,
  input  logic rstN,
  input  logic pipeOutRead,
  output logic [`HL_WORD_W-1:0] pipeOutData,
  input  logic usEnable,
  input  logic popValid,
  input  hostLinkPkg::usWord_t popData,
  output logic popReady,
  output logic padSeen
);

  // filler for reads with nothing to send
  localparam hostLinkPkg::usWord_t nopWord = {
    `HL_CODE_W'(`HL_NOP_CODE),
    {(`HL_WORD_W - `HL_CODE_W){1'b0}}
  };

  // read strobe from the previous edge
  logic readQ;
  logic haveWord;

  // ------------------------------------------------------------
  // pop decision
  // ------------------------------------------------------------
  // a pending read is served from the queue when allowed
  assign haveWord = usEnable & popValid;
  assign popReady = readQ & usEnable;
  // otherwise the read gets a NOP word
  assign padSeen = readQ & ~haveWord;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      readQ <= 1'b0;
      pipeOutData <= '0;
    end else begin
      readQ <= pipeOutRead;
      // word holds until the next read
      if (readQ) begin
        pipeOutData <= haveWord ? popData : nopWord;
      end
    end
  end

endmodule

/* hdl/linkRegs.sv */
`include "hostLink_consts.svh"

module linkRegs #(
  parameter int addrW = 8,
  parameter int dsLevelW = 5,
  parameter int usLevelW = 5
) (
  input  logic clk,
  input  logic rstN,
  // write address
  input  logic [addrW-1:0] awAddr,
  input  logic awValid,
  output logic awReady,
  // write data
  input  logic [`HL_WORD_W-1:0] wData,
  input  logic wValid,
  output logic wReady,
  // write response
  output logic [1:0] bResp,
  output logic bValid,
  input  logic bReady,
  // read address
  input  logic [addrW-1:0] arAddr,
  input  logic arValid,
  output logic arReady,
  // read data
  output logic [`HL_WORD_W-1:0] rData,
  output logic [1:0] rResp,
  output logic rValid,
  input  logic rReady,
  // control and status
  output logic dsEnable,
  output logic usEnable,
  output logic flush,
  input  logic [dsLevelW-1:0] dsLevel,
  input  logic [usLevelW-1:0] usLevel,
  input  logic dsPush,
  input  logic nopSeen,
  input  logic padSeen
);

  localparam logic [1:0] respOkay = 2'b00;

  logic awFire;
  logic wFire;
  logic arFire;
  logic awSeen;
  logic wSeen;
  logic [addrW-1:0] awAddrQ;
  logic [`HL_WORD_W-1:0] wDataQ;
  logic writeGo;
  logic [addrW-1:0] wrAddr;
  logic [`HL_WORD_W-1:0] wrData;
  logic [`HL_WORD_W-1:0] readMux;

  // event counters
  logic [`HL_WORD_W-1:0] dsCount;
  logic [`HL_WORD_W-1:0] nopCount;
  logic [`HL_WORD_W-1:0] padCount;

  assign bResp = respOkay;
  assign rResp = respOkay;

  assign awFire = awValid & awReady;
  assign wFire = wValid & wReady;
  assign arFire = arValid & arReady;

  // ------------------------------------------------------------
  // write path
  // ------------------------------------------------------------
  // take address and data from the latch, or live from the bus
  assign wrAddr = awSeen ? awAddrQ : awAddr;
  assign wrData = wSeen ? wDataQ : wData;
  // commits on the edge where the later of the two arrives
  assign writeGo = (awSeen | awFire) & (wSeen | wFire) & ~bValid;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      awReady <= 1'b0;
      wReady <= 1'b0;
      awSeen <= 1'b0;
      wSeen <= 1'b0;
      bValid <= 1'b0;
      dsEnable <= 1'b0;
      usEnable <= 1'b0;
      flush <= 1'b0;
      dsCount <= '0;
      nopCount <= '0;
      padCount <= '0;
    end else begin
      // readies are single cycle pulses, one transaction at a time
      awReady <= ~awReady & awValid & ~awSeen & ~bValid;
      wReady <= ~wReady & wValid & ~wSeen & ~bValid;
      flush <= 1'b0;

      if (writeGo) begin
        awSeen <= 1'b0;
        wSeen <= 1'b0;
        bValid <= 1'b1;
      end else begin
        if (awFire) awSeen <= 1'b1;
        if (wFire) wSeen <= 1'b1;
        if (bValid && bReady) bValid <= 1'b0;
      end

      // counters, a write to the offset clears
      if (writeGo && wrAddr == addrW'(`HL_REG_DSCOUNT)) begin
        dsCount <= '0;
      end else if (dsPush) begin
        dsCount <= dsCount + 1'b1;
      end
      if (writeGo && wrAddr == addrW'(`HL_REG_NOPCOUNT)) begin
        nopCount <= '0;
      end else if (nopSeen) begin
        nopCount <= nopCount + 1'b1;
      end
      if (writeGo && wrAddr == addrW'(`HL_REG_PADCOUNT)) begin
        padCount <= '0;
      end else if (padSeen) begin
        padCount <= padCount + 1'b1;
      end

      // ctrl, bit2 only fires the flush pulse
      if (writeGo && wrAddr == addrW'(`HL_REG_CTRL)) begin
        dsEnable <= wrData[0];
        usEnable <= wrData[1];
        flush <= wrData[2];
      end
    end
  end

  // latched halves of a split write
  always_ff @(posedge clk) begin
    if (awFire) awAddrQ <= awAddr;
    if (wFire) wDataQ <= wData;
  end

  // ------------------------------------------------------------
  // read path
  // ------------------------------------------------------------
  always_comb begin
    readMux = '0;
    case (arAddr)
      addrW'(`HL_REG_CTRL): readMux = {30'd0, usEnable, dsEnable};
      addrW'(`HL_REG_STATUS): readMux = {16'd0, 8'(usLevel), 8'(dsLevel)};
      addrW'(`HL_REG_DSCOUNT): readMux = dsCount;
      addrW'(`HL_REG_NOPCOUNT): readMux = nopCount;
      addrW'(`HL_REG_PADCOUNT): readMux = padCount;
      // unknown offsets read as zero
      default: readMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      arReady <= 1'b0;
      rValid <= 1'b0;
    end else begin
      arReady <= ~arReady & arValid & ~rValid;
      if (arFire) begin
        rValid <= 1'b1;
      end else if (rValid && rReady) begin
        rValid <= 1'b0;
      end
    end
  end

  // read data is captured with the address
  always_ff @(posedge clk) begin
    if (arFire) rData <= readMux;
  end

endmodule

/* hdl/hostLinkTop.sv */
`include "hostLink_consts.svh"

module hostLinkTop (
  input  logic clk,
  input  logic rstN,
  // host pipe-in
  input  logic pipeInWrite,
  input  logic [`HL_WORD_W-1:0] pipeInData,
  output logic pipeInReady,
  // host pipe-out
  input  logic pipeOutRead,
  output logic [`HL_WORD_W-1:0] pipeOutData,
  // downstream channel
  output logic dsValid,
  output logic [`HL_CODE_W-1:0] dsCode,
  output logic [`HL_WORD_W-`HL_CODE_W-1:0] dsPayload,
  input  logic dsReady,
  // upstream channel
  input  logic usValid,
  input  logic [`HL_WORD_W-1:0] usData,
  output logic usReady,
  // AXI4-Lite
  input  logic [7:0] awAddr,
  input  logic awValid,
  output logic awReady,
  input  logic [`HL_WORD_W-1:0] wData,
  input  logic wValid,
  output logic wReady,
  output logic [1:0] bResp,
  output logic bValid,
  input  logic bReady,
  input  logic [7:0] arAddr,
  input  logic arValid,
  output logic arReady,
  output logic [`HL_WORD_W-1:0] rData,
  output logic [1:0] rResp,
  output logic rValid,
  input  logic rReady
);

  localparam int dsLevelW = $clog2(`HL_DS_DEPTH + 1);
  localparam int usLevelW = $clog2(`HL_US_DEPTH + 1);

  logic dsEnable;
  logic usEnable;
  logic flush;
  logic dsPush;
  logic dsFull;
  logic usFull;
  logic nopSeen;
  logic padSeen;
  logic [dsLevelW-1:0] dsLevel;
  logic [usLevelW-1:0] usLevel;
  logic usPopValid;
  logic usPopReady;
  hostLinkPkg::dsWord_t dsPushData;
  hostLinkPkg::dsWord_t dsHead;
  hostLinkPkg::usWord_t usHead;

  // downstream head split onto the channel
  assign dsCode = dsHead.code;
  assign dsPayload = dsHead.payload;
  assign usReady = ~usFull;

  linkRegs #(
    .addrW(8),
    .dsLevelW(dsLevelW),
    .usLevelW(usLevelW)
  ) u_regs (
    .clk(clk), .rstN(rstN),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .dsEnable(dsEnable), .usEnable(usEnable), .flush(flush),
    .dsLevel(dsLevel), .usLevel(usLevel),
    .dsPush(dsPush), .nopSeen(nopSeen), .padSeen(padSeen)
  );

  // ------------------------------------------------------------
  // downstream path
  // ------------------------------------------------------------
  pipeInDecoder u_decoder (
    .pipeInWrite(pipeInWrite), .pipeInData(pipeInData), .pipeInReady(pipeInReady),
    .dsEnable(dsEnable), .fifoFull(dsFull),
    .pushValid(dsPush), .pushData(dsPushData), .nopSeen(nopSeen)
  );

  wordFifo #(
    .itemType(hostLinkPkg::dsWord_t),
    .depth(`HL_DS_DEPTH)
  ) u_dsFifo (
    .clk(clk), .rstN(rstN), .flush(flush),
    .pushValid(dsPush), .pushData(dsPushData), .full(dsFull),
    .popReady(dsReady), .popValid(dsValid), .popData(dsHead),
    .level(dsLevel)
  );

  // ------------------------------------------------------------
  // upstream path
  // ------------------------------------------------------------
  wordFifo #(
    .itemType(hostLinkPkg::usWord_t),
    .depth(`HL_US_DEPTH)
  ) u_usFifo (
    .clk(clk), .rstN(rstN), .flush(flush),
    .pushValid(usValid), .pushData(usData), .full(usFull),
    .popReady(usPopReady), .popValid(usPopValid), .popData(usHead),
    .level(usLevel)
  );

  pipeOutPacker u_packer (
    .clk(clk), .rstN(rstN),
    .pipeOutRead(pipeOutRead), .pipeOutData(pipeOutData),
    .usEnable(usEnable), .popValid(usPopValid), .popData(usHead),
    .popReady(usPopReady), .padSeen(padSeen)
  );

endmodule

/* test/hostLinkTb.sv */
`include "hostLink_consts.svh"

module hostLinkTb;

  localparam int timeoutCycles = 400;
  // AXI4-Lite OKAY response code
  localparam logic [1:0] okayResp = 2'b00;

  logic clk;
  logic rstN;
  logic pipeInWrite;
  logic [`HL_WORD_W-1:0] pipeInData;
  logic pipeInReady;
  logic pipeOutRead;
  logic [`HL_WORD_W-1:0] pipeOutData;
  logic dsValid;
  logic [`HL_CODE_W-1:0] dsCode;
  logic [`HL_WORD_W-`HL_CODE_W-1:0] dsPayload;
  logic dsReady;
  logic usValid;
  logic [`HL_WORD_W-1:0] usData;
  logic usReady;
  logic [7:0] awAddr;
  logic awValid;
  logic awReady;
  logic [`HL_WORD_W-1:0] wData;
  logic wValid;
  logic wReady;
  logic [1:0] bResp;
  logic bValid;
  logic bReady;
  logic [7:0] arAddr;
  logic arValid;
  logic arReady;
  logic [`HL_WORD_W-1:0] rData;
  logic [1:0] rResp;
  logic rValid;
  logic rReady;

  // ------------------------------------------------------------
  // reference model state
  // ------------------------------------------------------------
  // words still owed on the downstream channel, in order
  hostLinkPkg::dsWord_t dsModel [$];
  // words sitting in the upstream queue
  hostLinkPkg::usWord_t usModel [$];
  int unsigned fwdTotal;
  int unsigned nopTotal;
  int unsigned padTotal;
  logic dsEnOn;
  logic usEnOn;
  // dsReady behavior: 0 low, 1 random, 2 high
  int dsMode;
  int unsigned seedVal;
  hostLinkPkg::dsWord_t monGot;
  hostLinkPkg::dsWord_t monExp;

  hostLinkTop u_dut (
    .clk(clk), .rstN(rstN),
    .pipeInWrite(pipeInWrite), .pipeInData(pipeInData), .pipeInReady(pipeInReady),
    .pipeOutRead(pipeOutRead), .pipeOutData(pipeOutData),
    .dsValid(dsValid), .dsCode(dsCode), .dsPayload(dsPayload), .dsReady(dsReady),
    .usValid(usValid), .usData(usData), .usReady(usReady),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady)
  );

  always #20 clk = ~clk;

  // ------------------------------------------------------------
  // error handling and compares
  // ------------------------------------------------------------
  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkDsWord(input hostLinkPkg::dsWord_t got, input hostLinkPkg::dsWord_t exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s code %02h payload %06h, expected code %02h payload %06h",
               $time, what, got.code, got.payload, exp.code, exp.payload);
      abortRun("downstream word differs from model");
    end
  endtask

  task automatic checkUsWord(input hostLinkPkg::usWord_t got, input hostLinkPkg::usWord_t exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %08h, expected %08h", $time, what, got, exp);
      abortRun("pipe-out word differs from expected");
    end
  endtask

  task automatic checkReg(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %08h, expected %08h", $time, what, got, exp);
      abortRun("register value differs from expected");
    end
  endtask

  task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
      abortRun("AXI response differs from expected");
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
      abortRun("flag differs from expected");
    end
  endtask

  // ------------------------------------------------------------
  // downstream ready driver and monitor
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (dsMode == 1) begin
      dsReady <= ($urandom % 2) != 0;
    end else begin
      dsReady <= (dsMode == 2);
    end
  end

  // a transfer seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rstN && dsValid && dsReady) begin
      if (dsModel.size() == 0) begin
        abortRun("a downstream word appeared although none was expected");
      end else begin
        monExp = dsModel.pop_front();
        monGot.code = dsCode;
        monGot.payload = dsPayload;
        checkDsWord(monGot, monExp, "downstream word");
      end
    end
  end

  // ------------------------------------------------------------
  // model updates
  // ------------------------------------------------------------
  // top byte is the opcode, NOP words are only counted
  task automatic modelPipeIn(input logic [31:0] word);
    hostLinkPkg::dsWord_t item;
    item.code = word[`HL_WORD_W-1 -: `HL_CODE_W];
    item.payload = word[`HL_WORD_W-`HL_CODE_W-1:0];
    if (item.code == `HL_CODE_W'(`HL_NOP_CODE)) begin
      nopTotal++;
    end else begin
      fwdTotal++;
      dsModel.push_back(item);
    end
  endtask

  task automatic modelWrite(input logic [7:0] addr, input logic [31:0] data);
    if (addr == 8'(`HL_REG_CTRL)) begin
      dsEnOn = data[0];
      usEnOn = data[1];
      // flush empties both queues
      if (data[2]) begin
        dsModel.delete();
        usModel.delete();
      end
    end
    if (addr == 8'(`HL_REG_DSCOUNT)) fwdTotal = 0;
    if (addr == 8'(`HL_REG_NOPCOUNT)) nopTotal = 0;
    if (addr == 8'(`HL_REG_PADCOUNT)) padTotal = 0;
  endtask

  // ------------------------------------------------------------
  // AXI4-Lite drivers
  // ------------------------------------------------------------
  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
    logic awDone;
    logic wDone;
    logic awHit;
    logic wHit;
    int waited;
    awDone = 1'b0;
    wDone = 1'b0;
    waited = 0;
    @(posedge clk);
    awAddr <= addr;
    awValid <= 1'b1;
    wData <= data;
    wValid <= 1'b1;
    bReady <= 1'b1;
    while (!(awDone && wDone)) begin
      @(negedge clk);
      awHit = awReady & ~awDone;
      wHit = wReady & ~wDone;
      @(posedge clk);
      if (awHit) begin
        awValid <= 1'b0;
        awDone = 1'b1;
      end
      if (wHit) begin
        wValid <= 1'b0;
        wDone = 1'b1;
      end
      waited++;
      if (waited > timeoutCycles) abortRun("timeout: AXI write address or data was not taken");
    end
    waited = 0;
    awDone = 1'b0;
    while (!awDone) begin
      @(negedge clk);
      awDone = bValid;
      if (awDone) checkResp(bResp, okayResp, "write response");
      @(posedge clk);
      waited++;
      if (!awDone && waited > timeoutCycles) abortRun("timeout: no AXI write response");
    end
    bReady <= 1'b0;
    modelWrite(addr, data);
  endtask

  task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
    logic done;
    int waited;
    done = 1'b0;
    waited = 0;
    data = '0;
    @(posedge clk);
    arAddr <= addr;
    arValid <= 1'b1;
    rReady <= 1'b1;
    while (!done) begin
      @(negedge clk);
      done = arReady;
      @(posedge clk);
      waited++;
      if (!done && waited > timeoutCycles) abortRun("timeout: AXI read address was not taken");
    end
    arValid <= 1'b0;
    done = 1'b0;
    waited = 0;
    while (!done) begin
      @(negedge clk);
      if (rValid) begin
        done = 1'b1;
        data = rData;
        checkResp(rResp, okayResp, "read response");
      end
      @(posedge clk);
      waited++;
      if (!done && waited > timeoutCycles) abortRun("timeout: no AXI read data");
    end
    rReady <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // pipe and channel drivers
  // ------------------------------------------------------------
  task automatic pipeInWord(input logic [31:0] word);
    logic taken;
    int waited;
    taken = 1'b0;
    waited = 0;
    @(posedge clk);
    pipeInWrite <= 1'b1;
    pipeInData <= word;
    while (!taken) begin
      @(negedge clk);
      if (pipeInReady) begin
        taken = 1'b1;
        modelPipeIn(word);
      end
      @(posedge clk);
      waited++;
      if (!taken && waited > timeoutCycles) abortRun("timeout: pipe-in word never accepted");
    end
    pipeInWrite <= 1'b0;
  endtask

  task automatic pushUpstream(input int count);
    hostLinkPkg::usWord_t word;
    logic taken;
    int waited;
    for (int i = 0; i < count; i++) begin
      word = $urandom;
      taken = 1'b0;
      waited = 0;
      @(posedge clk);
      usValid <= 1'b1;
      usData <= word;
      while (!taken) begin
        @(negedge clk);
        if (usReady) begin
          taken = 1'b1;
          usModel.push_back(word);
        end
        @(posedge clk);
        waited++;
        if (!taken && waited > timeoutCycles) abortRun("timeout: upstream queue never ready");
      end
      usValid <= 1'b0;
    end
  endtask

  // read data shows one edge after the read is sampled
  task automatic pipeOutWord(input logic fromQueue, input logic [31:0] nopExp);
    hostLinkPkg::usWord_t exp;
    logic modelQueue;
    modelQueue = usEnOn && (usModel.size() > 0);
    if (modelQueue != fromQueue) begin
      abortRun("stimulus and model disagree on whether a pipe-out read gets a queued word");
    end
    if (modelQueue) begin
      exp = usModel.pop_front();
    end else begin
      exp = nopExp;
      padTotal++;
    end
    @(posedge clk);
    pipeOutRead <= 1'b1;
    @(posedge clk);
    pipeOutRead <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkUsWord(pipeOutData, exp, "pipe-out word");
  endtask

  task automatic drainDownstream(input int mode);
    int waited;
    waited = 0;
    @(negedge clk);
    dsMode = mode;
    while (dsModel.size() > 0) begin
      @(posedge clk);
      waited++;
      if (waited > timeoutCycles) abortRun("timeout: downstream words still missing");
    end
    @(negedge clk);
    dsMode = 0;
  endtask

  task automatic checkCounter(input int which);
    logic [31:0] got;
    logic [7:0] addr;
    logic [31:0] exp;
    case (which)
      0: begin
        addr = 8'(`HL_REG_DSCOUNT);
        exp = fwdTotal;
      end
      1: begin
        addr = 8'(`HL_REG_NOPCOUNT);
        exp = nopTotal;
      end
      default: begin
        addr = 8'(`HL_REG_PADCOUNT);
        exp = padTotal;
      end
    endcase
    readReg(addr, got);
    checkReg(got, exp, $sformatf("counter at 0x%02h", addr));
  endtask

  // ------------------------------------------------------------
  // stimulus file
  // ------------------------------------------------------------
  task automatic runOp(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] got;
    case (op)
      "W": writeReg(a[7:0], b);
      "R": begin
        readReg(a[7:0], got);
        checkReg(got, b, $sformatf("register 0x%02h", a[7:0]));
      end
      "I": pipeInWord(a);
      "B": for (int i = 0; i < a; i++) pipeInWord(b + i);
      "U": pushUpstream(a);
      "O": pipeOutWord(a[0], b);
      "M": begin
        @(negedge clk);
        dsMode = a;
      end
      "D": drainDownstream(a);
      "P": begin
        @(negedge clk);
        checkFlag(pipeInReady, a[0], "pipeInReady");
      end
      "C": checkCounter(a);
      "N": repeat (a) @(posedge clk);
      default: abortRun($sformatf("unknown operation %c in the stimulus file", op));
    endcase
  endtask

  task automatic runStimulus();
    int fd;
    int rc;
    string lineText;
    logic [7:0] op;
    logic [31:0] argA;
    logic [31:0] argB;
    fd = $fopen("test/hostLink_stimulus.txt", "r");
    if (fd == 0) abortRun("could not open test/hostLink_stimulus.txt");
    while (!$feof(fd)) begin
      lineText = "";
      rc = $fgets(lineText, fd);
      // skip blank and comment lines
      if (lineText.len() < 3 || lineText[0] == "#") continue;
      rc = $sscanf(lineText, "%c %h %h", op, argA, argB);
      if (rc != 3) abortRun({"malformed stimulus line: ", lineText});
      runOp(op, argA, argB);
    end
    $fclose(fd);
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    pipeInWrite = 1'b0;
    pipeInData = '0;
    pipeOutRead = 1'b0;
    dsReady = 1'b0;
    usValid = 1'b0;
    usData = '0;
    awAddr = '0;
    awValid = 1'b0;
    wData = '0;
    wValid = 1'b0;
    bReady = 1'b0;
    arAddr = '0;
    arValid = 1'b0;
    rReady = 1'b0;
    fwdTotal = 0;
    nopTotal = 0;
    padTotal = 0;
    dsEnOn = 1'b0;
    usEnOn = 1'b0;
    dsMode = 0;
    seedVal = $urandom(32'h74dbc4e1);
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    runStimulus();
    // let any stray downstream word show up
    repeat (4) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
hdl/hostLinkPkg.sv
hdl/wordFifo.sv
hdl/pipeInDecoder.sv
hdl/pipeOutPacker.sv
hdl/linkRegs.sv
hdl/hostLinkTop.sv
test/hostLinkTb.sv

/* test/hostLink_stimulus.txt */
# op a b, all hex: W reg write (addr data), R reg read (addr expected), I pipe-in word a
# B burst of a words from b, U push a random upstream words, O pipe-out read (a=1 queued, else b)
# M dsReady mode a (0 low 1 random 2 high), D drain in mode a, P expected pipeInReady a
# C counter a against model (0 fwd 1 nop 2 pad), N idle a cycles
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000000
P 0 0
W 00 00000006
R 00 00000002
W 00 00000001
R 00 00000001
P 1 0
M 1 0
I 01123456 0
I 40000000 0
I 02abcdef 0
I 40ffffff 0
I 40000000 0
I ff000001 0
I 00000000 0
I 3f7fffff 0
I 41000010 0
D 1 0
M 0 0
B 10 05000000
P 0 0
R 04 00000010
D 1 0
U 3 0
R 04 00000300
O 0 40000000
O 0 40000000
R 04 00000300
W 00 00000003
O 1 0
O 1 0
O 1 0
O 0 40000000
O 0 40000000
R 04 00000000
C 0 0
C 1 0
C 2 0
W 08 00000000
R 08 00000000
W 0C 00000000
R 0C 00000000
W 10 00000000
R 10 00000000
M 0 0
B 4 07000000
U 2 0
R 04 00000204
W 00 00000007
R 04 00000000
R 00 00000003
M 1 0
N 20 0
O 0 40000000
C 0 0
C 2 0
